// ==== bench/tb_esprit_eigen.sv ====
module tb_esprit_eigen;

    localparam int DIN_WIDTH  = eig_pkg::DEF_DIN_WIDTH;
    localparam int DIN_POINT  = eig_pkg::DEF_DIN_POINT;
    // two bits narrower than the default word so that full-scale inputs reach the clamp
    localparam int DOUT_WIDTH = eig_pkg::DEF_DOUT_WIDTH - 2;
    localparam int DOUT_POINT = eig_pkg::DEF_DOUT_POINT;
    localparam int BANDS      = eig_pkg::DEF_BANDS;
    localparam int NUM_LANES  = eig_pkg::DEF_NUM_LANES;
    localparam int FIFO_DEPTH = eig_pkg::DEF_FIFO_DEPTH;
    localparam int BW         = $clog2(BANDS);
    localparam int SHIFT      = DIN_POINT - DOUT_POINT;
    localparam int EW         = 5 * DOUT_WIDTH + 1 + BW;

    localparam int N_DIAG    = 4;
    localparam int N_RANDOM  = 200;
    localparam int N_BURST   = 24;
    localparam int N_SAT     = 3;
    localparam int N_SAMPLES = N_DIAG + N_RANDOM + N_BURST + N_SAT + BANDS;
    localparam int WATCHDOG  = (N_SAMPLES + 10) * (DIN_WIDTH + 10) * 100;

    localparam longint SAT_HI = (longint'(1) <<< (DOUT_WIDTH - 1)) - 1;
    localparam longint SAT_LO = -SAT_HI - 1;

    logic                         clk = 1'b0;
    logic                         rst;
    logic [DIN_WIDTH-1:0]         r11;
    logic [DIN_WIDTH-1:0]         r22;
    logic signed [DIN_WIDTH-1:0]  r12;
    logic                         din_valid;
    logic [BW-1:0]                band_in;
    logic signed [DOUT_WIDTH-1:0] lamb1;
    logic signed [DOUT_WIDTH-1:0] lamb2;
    logic signed [DOUT_WIDTH-1:0] eigen1_y;
    logic signed [DOUT_WIDTH-1:0] eigen2_y;
    logic signed [DOUT_WIDTH-1:0] eigen_x;
    logic                         dout_valid;
    logic                         dout_error;
    logic [BW-1:0]                band_out;
    logic                         fifo_full;

    // expected results in input order: five words, error flag, band
    logic [EW-1:0] exp_q [$];
    int            seed;
    logic          saw_full;

    esprit_eigen_top #(
        .DIN_WIDTH (DIN_WIDTH),
        .DIN_POINT (DIN_POINT),
        .DOUT_WIDTH(DOUT_WIDTH),
        .DOUT_POINT(DOUT_POINT),
        .BANDS     (BANDS),
        .NUM_LANES (NUM_LANES),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_esprit_eigen_top (
        .clk       (clk),
        .rst       (rst),
        .r11       (r11),
        .r22       (r22),
        .r12       (r12),
        .din_valid (din_valid),
        .band_in   (band_in),
        .lamb1     (lamb1),
        .lamb2     (lamb2),
        .eigen1_y  (eigen1_y),
        .eigen2_y  (eigen2_y),
        .eigen_x   (eigen_x),
        .dout_valid(dout_valid),
        .dout_error(dout_error),
        .band_out  (band_out),
        .fifo_full (fifo_full)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_word(input string name, input logic signed [DOUT_WIDTH-1:0] got,
                              input logic signed [DOUT_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_band(input string name, input logic [BW-1:0] got,
                              input logic [BW-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // greedy bitwise floor square root
    function automatic longint int_sqrt(input longint v);
        longint r;
        longint bit_v;
        r = 0;
        for (int b = 24; b >= 0; b--) begin
            bit_v = longint'(1) << b;
            if ((r + bit_v) * (r + bit_v) <= v) begin
                r = r + bit_v;
            end
        end
        return r;
    endfunction

    task automatic predict_result(input logic [DIN_WIDTH-1:0] a11, input logic [DIN_WIDTH-1:0] a22,
                                  input logic signed [DIN_WIDTH-1:0] a12,
                                  input logic [BW-1:0] bnd);
        longint                t;
        longint                df;
        longint                s;
        longint                q;
        longint                v [5];
        logic [DOUT_WIDTH-1:0] w [5];
        logic                  err;
        t    = longint'(a11) + longint'(a22);
        df   = longint'(a11) - longint'(a22);
        s    = int_sqrt(df * df + 4 * longint'(a12) * longint'(a12));
        v[0] = (t + s) >>> 1;
        v[1] = (t - s) >>> 1;
        v[2] = v[0] - longint'(a11);
        v[3] = v[1] - longint'(a11);
        v[4] = longint'(a12);
        err  = 1'b0;
        for (int i = 0; i < 5; i++) begin
            q = v[i] >>> SHIFT;
            if (q > SAT_HI) begin
                q   = SAT_HI;
                err = 1'b1;
            end else if (q < SAT_LO) begin
                q   = SAT_LO;
                err = 1'b1;
            end
            w[i] = DOUT_WIDTH'(q);
        end
        exp_q.push_back({w[0], w[1], w[2], w[3], w[4], err, bnd});
    endtask

    // present one sample; an offer that meets a full FIFO is dropped and retried later
    task automatic offer_sample(input logic [DIN_WIDTH-1:0] a11, input logic [DIN_WIDTH-1:0] a22,
                                input logic signed [DIN_WIDTH-1:0] a12,
                                input logic [BW-1:0] bnd);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            r11       <= a11;
            r22       <= a22;
            r12       <= a12;
            band_in   <= bnd;
            din_valid <= 1'b1;
            @(negedge clk);
            if (!fifo_full) begin
                accepted = 1'b1;
            end else begin
                saw_full = 1'b1;
                @(posedge clk);
                din_valid <= 1'b0;
                @(negedge clk);
                while (fifo_full) begin
                    @(negedge clk);
                end
            end
        end
        predict_result(a11, a22, a12, bnd);
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        din_valid <= 1'b0;
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic test_reset_quiet();
        repeat (6) begin
            @(negedge clk);
            check_flag("dout_valid", dout_valid, 1'b0);
            check_flag("dout_error", dout_error, 1'b0);
            check_flag("fifo_full", fifo_full, 1'b0);
        end
    endtask

    // r12 = 0, eigenvalues are the diagonal entries
    task automatic test_diagonal();
        offer_sample(16'd1000, 16'd3000, 16'sd0, 2'd0);
        offer_sample(16'd3000, 16'd1000, 16'sd0, 2'd1);
        offer_sample(16'd20000, 16'd20000, 16'sd0, 2'd2);
        offer_sample(16'd0, 16'd5000, 16'sd0, 2'd3);
        idle_inputs();
        wait_results();
    endtask

    task automatic test_random();
        int                          rnd;
        logic [DIN_WIDTH-1:0]        a11;
        logic [DIN_WIDTH-1:0]        a22;
        logic signed [DIN_WIDTH-1:0] a12;
        logic [BW-1:0]               bnd;
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            a11 = DIN_WIDTH'(rnd & 32'h1fff);
            a12 = DIN_WIDTH'($signed(rnd[28:16]));
            rnd = $random(seed);
            a22 = DIN_WIDTH'(rnd & 32'h1fff);
            bnd = BW'(rnd[23:16] % BANDS);
            offer_sample(a11, a22, a12, bnd);
        end
        idle_inputs();
        wait_results();
    endtask

    // one sample per cycle, the lanes cannot keep up so the FIFO fills
    task automatic test_burst();
        int rnd;
        saw_full = 1'b0;
        for (int i = 0; i < N_BURST; i++) begin
            rnd = $random(seed);
            offer_sample(DIN_WIDTH'(rnd & 32'h0fff), DIN_WIDTH'((rnd >>> 12) & 32'h0fff),
                         DIN_WIDTH'(i * 37 - 400), BW'(i));
        end
        idle_inputs();
        if (!saw_full) begin
            $display("fifo_full never went high during the back-to-back burst");
            abort_run();
        end
        wait_results();
    endtask

    task automatic test_saturation();
        offer_sample(16'd40000, 16'd0, 16'sd0, 2'd1);
        offer_sample(16'd0, 16'd60000, 16'sd0, 2'd2);
        offer_sample(16'd30000, 16'd30000, 16'sd16000, 2'd3);
        idle_inputs();
        wait_results();
    endtask

    task automatic test_bands();
        for (int b = 0; b < BANDS; b++) begin
            offer_sample(DIN_WIDTH'(100 * (b + 1)), 16'd50, DIN_WIDTH'(10 - 7 * b), BW'(b));
        end
        idle_inputs();
        wait_results();
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin : result_check
        logic signed [DOUT_WIDTH-1:0] e_l1;
        logic signed [DOUT_WIDTH-1:0] e_l2;
        logic signed [DOUT_WIDTH-1:0] e_y1;
        logic signed [DOUT_WIDTH-1:0] e_y2;
        logic signed [DOUT_WIDTH-1:0] e_x;
        logic                         e_err;
        logic [BW-1:0]                e_band;
        if (dout_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("dout_valid went high with no sample outstanding at %0t", $time);
                abort_run();
            end else begin
                {e_l1, e_l2, e_y1, e_y2, e_x, e_err, e_band} = exp_q.pop_front();
                check_word("lamb1", lamb1, e_l1);
                check_word("lamb2", lamb2, e_l2);
                check_word("eigen1_y", eigen1_y, e_y1);
                check_word("eigen2_y", eigen2_y, e_y2);
                check_word("eigen_x", eigen_x, e_x);
                check_flag("dout_error", dout_error, e_err);
                check_band("band_out", band_out, e_band);
            end
        end
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: results still missing after %0d time units", WATCHDOG);
        abort_run();
    end

    initial begin
        seed      = 32'h5121;
        saw_full  = 1'b0;
        rst       = 1'b1;
        din_valid = 1'b0;
        r11       = '0;
        r22       = '0;
        r12       = '0;
        band_in   = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        test_reset_quiet();
        test_diagonal();
        test_random();
        test_burst();
        test_saturation();
        test_bands();

        // nothing further may come out once every sample is answered
        repeat (DIN_WIDTH + 10) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== hw/eig_collect.sv ====
module eig_collect #(
    parameter int DIN_WIDTH  = 16,
    parameter int DIN_POINT  = 15,
    parameter int DOUT_WIDTH = 16,
    parameter int DOUT_POINT = 13,
    parameter int BANDS      = 4,
    parameter int NUM_LANES  = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    lane_if.collect_mp                    lanes [NUM_LANES],
    output logic signed [DOUT_WIDTH-1:0]  lamb1,
    output logic signed [DOUT_WIDTH-1:0]  lamb2,
    output logic signed [DOUT_WIDTH-1:0]  eigen1_y,
    output logic signed [DOUT_WIDTH-1:0]  eigen2_y,
    output logic signed [DOUT_WIDTH-1:0]  eigen_x,
    output logic                          dout_valid,
    output logic                          dout_error,
    output logic [$clog2(BANDS)-1:0]      band_out
);
    localparam int BW    = $clog2(BANDS);
    localparam int LW    = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int SHIFT = DIN_POINT - DOUT_POINT;
    // wide enough for t+s and lamb2-r11 with sign
    localparam int CW    = DIN_WIDTH + 3;
    localparam int XW    = CW + DOUT_WIDTH;
    localparam logic signed [XW-1:0] SAT_MAX = (XW'(1) <<< (DOUT_WIDTH - 1)) - 1;
    localparam logic signed [XW-1:0] SAT_MIN = -SAT_MAX - 1;

    logic [NUM_LANES-1:0] done_vec;
    logic [DIN_WIDTH:0]   s_arr    [NUM_LANES];
    logic [DIN_WIDTH:0]   t_arr    [NUM_LANES];
    logic [DIN_WIDTH-1:0] r11_arr  [NUM_LANES];
    logic [DIN_WIDTH-1:0] r12_arr  [NUM_LANES];
    logic [BW-1:0]        band_arr [NUM_LANES];
    logic [LW-1:0]        cptr;
    logic                 take;

    logic signed [CW-1:0] t_x, s_x, r11_x, x_x;
    logic signed [CW-1:0] lam1_x, lam2_x, y1_x, y2_x;
    logic [DOUT_WIDTH:0]  lam1_q, lam2_q, y1_q, y2_q, x_q;

    // shift to the output point and clamp, flag in the top bit
    function automatic logic [DOUT_WIDTH:0] rescale(input logic signed [CW-1:0] v);
        logic signed [XW-1:0] x;
        logic                 ovf;
        x   = XW'(v) >>> SHIFT;
        ovf = (x > SAT_MAX) || (x < SAT_MIN);
        if (!ovf) begin
            return {1'b0, x[DOUT_WIDTH-1:0]};
        end
        return {1'b1, (x < 0) ? SAT_MIN[DOUT_WIDTH-1:0] : SAT_MAX[DOUT_WIDTH-1:0]};
    endfunction

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_tap
        assign done_vec[i] = lanes[i].done;
        assign s_arr[i]    = lanes[i].s;
        assign t_arr[i]    = lanes[i].res_t;
        assign r11_arr[i]  = lanes[i].res_r11;
        assign r12_arr[i]  = lanes[i].res_r12;
        assign band_arr[i] = lanes[i].res_band;
    end

    // lanes finish in the order they were started
    assign take = done_vec[cptr];

    always_comb begin
        t_x    = CW'(t_arr[cptr]);
        s_x    = CW'(s_arr[cptr]);
        r11_x  = CW'(r11_arr[cptr]);
        x_x    = CW'($signed(r12_arr[cptr]));
        lam1_x = (t_x + s_x) >>> 1;
        lam2_x = (t_x - s_x) >>> 1;
        y1_x   = lam1_x - r11_x;
        y2_x   = lam2_x - r11_x;
    end

    assign lam1_q = rescale(lam1_x);
    assign lam2_q = rescale(lam2_x);
    assign y1_q   = rescale(y1_x);
    assign y2_q   = rescale(y2_x);
    assign x_q    = rescale(x_x);

    always_ff @(posedge clk) begin
        if (rst) begin
            cptr       <= '0;
            dout_valid <= 1'b0;
            dout_error <= 1'b0;
        end else begin
            dout_valid <= take;
            dout_error <= take && (lam1_q[DOUT_WIDTH] || lam2_q[DOUT_WIDTH] ||
                          y1_q[DOUT_WIDTH] || y2_q[DOUT_WIDTH] || x_q[DOUT_WIDTH]);
            if (take) begin
                cptr <= (cptr == LW'(NUM_LANES - 1)) ? '0 : cptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            lamb1    <= lam1_q[DOUT_WIDTH-1:0];
            lamb2    <= lam2_q[DOUT_WIDTH-1:0];
            eigen1_y <= y1_q[DOUT_WIDTH-1:0];
            eigen2_y <= y2_q[DOUT_WIDTH-1:0];
            eigen_x  <= x_q[DOUT_WIDTH-1:0];
            band_out <= band_arr[cptr];
        end
    end

endmodule

// ==== hw/eig_dispatch.sv ====
module eig_dispatch #(
    parameter int DIN_WIDTH = 16,
    parameter int BANDS     = 4,
    parameter int NUM_LANES = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [3*DIN_WIDTH+$clog2(BANDS)-1:0] fifo_data,
    input  logic                                fifo_empty,
    output logic                                fifo_pop,
    lane_if.dispatch_mp                         lanes [NUM_LANES]
);
    localparam int BW = $clog2(BANDS);
    localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [DIN_WIDTH-1:0]          in_r11;
    logic [DIN_WIDTH-1:0]          in_r22;
    logic [DIN_WIDTH-1:0]          in_r12;
    logic [BW-1:0]                 in_band;
    logic [NUM_LANES-1:0]          idle_vec;
    logic [NUM_LANES-1:0]          rsv;
    logic [LW-1:0]                 ptr;

    logic                          s1_valid;
    logic [LW-1:0]                 s1_lane;
    logic [DIN_WIDTH:0]            s1_t;
    logic signed [DIN_WIDTH:0]     s1_diff;
    logic [DIN_WIDTH-1:0]          s1_r11;
    logic signed [DIN_WIDTH-1:0]   s1_r12;
    logic [BW-1:0]                 s1_band;

    eig_pkg::dispatch_state_e      s2_state;
    logic [LW-1:0]                 s2_lane;
    logic [DIN_WIDTH:0]            s2_t;
    logic [2*DIN_WIDTH+1:0]        s2_d;
    logic [DIN_WIDTH-1:0]          s2_r11;
    logic [DIN_WIDTH-1:0]          s2_r12;
    logic [BW-1:0]                 s2_band;

    logic signed [2*DIN_WIDTH+1:0] diff_sq;
    logic signed [2*DIN_WIDTH+1:0] r12_sq;

    assign {in_r11, in_r22, in_r12, in_band} = fifo_data;

    // pop only into a lane that is idle and not already claimed by stage 1 or 2
    assign fifo_pop = !fifo_empty && idle_vec[ptr] && !rsv[ptr];

    assign diff_sq = (2 * DIN_WIDTH + 2)'(s1_diff) * (2 * DIN_WIDTH + 2)'(s1_diff);
    assign r12_sq  = (2 * DIN_WIDTH + 2)'(s1_r12) * (2 * DIN_WIDTH + 2)'(s1_r12);

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign idle_vec[i]    = lanes[i].idle;
        assign lanes[i].start = (s2_state == eig_pkg::DSP_ISSUE) && (s2_lane == LW'(i));
        // operands are shared, only start selects the lane
        assign lanes[i].t     = s2_t;
        assign lanes[i].d     = s2_d;
        assign lanes[i].r11   = s2_r11;
        assign lanes[i].r12   = s2_r12;
        assign lanes[i].band  = s2_band;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr      <= '0;
            rsv      <= '0;
            s1_valid <= 1'b0;
            s2_state <= eig_pkg::DSP_WAIT;
        end else begin
            s1_valid <= fifo_pop;
            s2_state <= s1_valid ? eig_pkg::DSP_ISSUE : eig_pkg::DSP_WAIT;
            // reservation lasts from pop until the lane sees start
            if (s2_state == eig_pkg::DSP_ISSUE) begin
                rsv[s2_lane] <= 1'b0;
            end
            if (fifo_pop) begin
                rsv[ptr] <= 1'b1;
                ptr      <= (ptr == LW'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
            end
        end
    end

    // stage 1: trace and difference
    always_ff @(posedge clk) begin
        s1_lane <= ptr;
        s1_t    <= {1'b0, in_r11} + {1'b0, in_r22};
        s1_diff <= $signed({1'b0, in_r11}) - $signed({1'b0, in_r22});
        s1_r11  <= in_r11;
        s1_r12  <= in_r12;
        s1_band <= in_band;
    end

    // stage 2: discriminant diff^2 + 4*r12^2
    always_ff @(posedge clk) begin
        s2_lane <= s1_lane;
        s2_t    <= s1_t;
        s2_d    <= $unsigned(diff_sq + (r12_sq <<< 2));
        s2_r11  <= s1_r11;
        s2_r12  <= s1_r12;
        s2_band <= s1_band;
    end

endmodule

// ==== hw/eig_pkg.sv ====
package eig_pkg;

    // root lane control
    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_ROOT,
        LANE_DONE
    } lane_state_e;

    // issue stage of the dispatch pipeline
    typedef enum logic {
        DSP_WAIT,
        DSP_ISSUE
    } dispatch_state_e;

    // default sizing, shared by the top level and the testbench model
    localparam int DEF_DIN_WIDTH  = 16;
    localparam int DEF_DIN_POINT  = 15;
    localparam int DEF_DOUT_WIDTH = 16;
    localparam int DEF_DOUT_POINT = 13;
    localparam int DEF_BANDS      = 4;
    localparam int DEF_NUM_LANES  = 4;
    localparam int DEF_FIFO_DEPTH = 8;

endpackage

// ==== hw/esprit_eigen_top.sv ====
module esprit_eigen_top #(
    parameter int DIN_WIDTH  = eig_pkg::DEF_DIN_WIDTH,
    parameter int DIN_POINT  = eig_pkg::DEF_DIN_POINT,
    parameter int DOUT_WIDTH = eig_pkg::DEF_DOUT_WIDTH,
    parameter int DOUT_POINT = eig_pkg::DEF_DOUT_POINT,
    parameter int BANDS      = eig_pkg::DEF_BANDS,
    parameter int NUM_LANES  = eig_pkg::DEF_NUM_LANES,
    parameter int FIFO_DEPTH = eig_pkg::DEF_FIFO_DEPTH
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [DIN_WIDTH-1:0]          r11,
    input  logic [DIN_WIDTH-1:0]          r22,
    input  logic signed [DIN_WIDTH-1:0]   r12,
    input  logic                          din_valid,
    input  logic [$clog2(BANDS)-1:0]      band_in,
    output logic signed [DOUT_WIDTH-1:0]  lamb1,
    output logic signed [DOUT_WIDTH-1:0]  lamb2,
    output logic signed [DOUT_WIDTH-1:0]  eigen1_y,
    output logic signed [DOUT_WIDTH-1:0]  eigen2_y,
    output logic signed [DOUT_WIDTH-1:0]  eigen_x,
    output logic                          dout_valid,
    output logic                          dout_error,
    output logic [$clog2(BANDS)-1:0]      band_out,
    output logic                          fifo_full
);
    localparam int PW = 3 * DIN_WIDTH + $clog2(BANDS);

    logic [PW-1:0] fifo_wdata;
    logic [PW-1:0] fifo_rdata;
    logic          fifo_pop;
    logic          fifo_empty;

    assign fifo_wdata = {r11, r22, r12, band_in};

    lane_if #(.DIN_WIDTH(DIN_WIDTH), .BANDS(BANDS)) lane_bus [NUM_LANES] ();

    sample_fifo #(
        .DIN_WIDTH (DIN_WIDTH),
        .BANDS     (BANDS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_sample_fifo (
        .clk    (clk),
        .rst    (rst),
        .push   (din_valid),
        .pop    (fifo_pop),
        .wr_data(fifo_wdata),
        .rd_data(fifo_rdata),
        .full   (fifo_full),
        .empty  (fifo_empty)
    );

    eig_dispatch #(
        .DIN_WIDTH(DIN_WIDTH),
        .BANDS    (BANDS),
        .NUM_LANES(NUM_LANES)
    ) u_eig_dispatch (
        .clk       (clk),
        .rst       (rst),
        .fifo_data (fifo_rdata),
        .fifo_empty(fifo_empty),
        .fifo_pop  (fifo_pop),
        .lanes     (lane_bus)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lanes
        sqrt_lane #(
            .DIN_WIDTH(DIN_WIDTH),
            .BANDS    (BANDS)
        ) u_sqrt_lane (
            .clk (clk),
            .rst (rst),
            .lane(lane_bus[i])
        );
    end

    eig_collect #(
        .DIN_WIDTH (DIN_WIDTH),
        .DIN_POINT (DIN_POINT),
        .DOUT_WIDTH(DOUT_WIDTH),
        .DOUT_POINT(DOUT_POINT),
        .BANDS     (BANDS),
        .NUM_LANES (NUM_LANES)
    ) u_eig_collect (
        .clk       (clk),
        .rst       (rst),
        .lanes     (lane_bus),
        .lamb1     (lamb1),
        .lamb2     (lamb2),
        .eigen1_y  (eigen1_y),
        .eigen2_y  (eigen2_y),
        .eigen_x   (eigen_x),
        .dout_valid(dout_valid),
        .dout_error(dout_error),
        .band_out  (band_out)
    );

endmodule

// ==== hw/lane_if.sv ====
interface lane_if #(
    parameter int DIN_WIDTH = 16,
    parameter int BANDS     = 4
);

    // operands from dispatch, valid with start
    logic                       start;
    logic [DIN_WIDTH:0]         t;
    logic [2*DIN_WIDTH+1:0]     d;
    logic [DIN_WIDTH-1:0]       r11;
    logic [DIN_WIDTH-1:0]       r12;
    logic [$clog2(BANDS)-1:0]   band;

    // lane status and result, valid with done
    logic                       idle;
    logic                       done;
    logic [DIN_WIDTH:0]         s;
    logic [DIN_WIDTH:0]         res_t;
    logic [DIN_WIDTH-1:0]       res_r11;
    logic [DIN_WIDTH-1:0]       res_r12;
    logic [$clog2(BANDS)-1:0]   res_band;

    modport dispatch_mp (
        output start, t, d, r11, r12, band,
        input  idle
    );

    modport lane_mp (
        input  start, t, d, r11, r12, band,
        output idle, done, s, res_t, res_r11, res_r12, res_band
    );

    modport collect_mp (
        input  done, s, res_t, res_r11, res_r12, res_band
    );

endinterface

// ==== hw/sample_fifo.sv ====
module sample_fifo #(
    parameter int DIN_WIDTH  = 16,
    parameter int BANDS      = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                push,
    input  logic                                pop,
    input  logic [3*DIN_WIDTH+$clog2(BANDS)-1:0] wr_data,
    output logic [3*DIN_WIDTH+$clog2(BANDS)-1:0] rd_data,
    output logic                                full,
    output logic                                empty
);
    localparam int PW = 3 * DIN_WIDTH + $clog2(BANDS);
    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [PW-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [AW:0]   count_next;
    logic          do_push;
    logic          do_pop;

    // a push into a full buffer is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign rd_data = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            full  <= (count_next == (AW + 1)'(FIFO_DEPTH));
            empty <= (count_next == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// ==== hw/sqrt_lane.sv ====
module sqrt_lane #(
    parameter int DIN_WIDTH = 16,
    parameter int BANDS     = 4
) (
    input  logic       clk,
    input  logic       rst,
    lane_if.lane_mp    lane
);
    // root bits; the radicand is twice as wide
    localparam int N  = DIN_WIDTH + 1;
    localparam int CW = $clog2(N);

    eig_pkg::lane_state_e state;
    logic [CW-1:0]        iter;
    logic [2*N-1:0]       rad;
    logic [N-1:0]         rem;
    logic [N-1:0]         root;
    logic [N+1:0]         rem_sh;
    logic [N+1:0]         trial;
    logic [N+2:0]         sub;

    // bring down the next two radicand bits and try root*4+1
    assign rem_sh = {rem, rad[2*N-1 -: 2]};
    assign trial  = {root, 2'b01};
    assign sub    = {1'b0, rem_sh} - {1'b0, trial};

    assign lane.idle = (state == eig_pkg::LANE_IDLE);
    assign lane.s    = root;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= eig_pkg::LANE_IDLE;
            lane.done <= 1'b0;
        end else begin
            lane.done <= 1'b0;
            case (state)
                eig_pkg::LANE_IDLE: begin
                    if (lane.start) begin
                        state <= eig_pkg::LANE_ROOT;
                    end
                end
                eig_pkg::LANE_ROOT: begin
                    if (iter == CW'(N - 1)) begin
                        state <= eig_pkg::LANE_DONE;
                    end
                end
                eig_pkg::LANE_DONE: begin
                    state     <= eig_pkg::LANE_IDLE;
                    lane.done <= 1'b1;
                end
                default: begin
                    state <= eig_pkg::LANE_IDLE;
                end
            endcase
        end
    end

    // datapath, one root bit per cycle in LANE_ROOT
    always_ff @(posedge clk) begin
        if (state == eig_pkg::LANE_IDLE && lane.start) begin
            rad           <= lane.d;
            rem           <= '0;
            root          <= '0;
            iter          <= '0;
            lane.res_t    <= lane.t;
            lane.res_r11  <= lane.r11;
            lane.res_r12  <= lane.r12;
            lane.res_band <= lane.band;
        end else if (state == eig_pkg::LANE_ROOT) begin
            rad  <= rad << 2;
            iter <= iter + 1'b1;
            if (sub[N+2]) begin
                // trial too large, keep the remainder
                rem  <= rem_sh[N-1:0];
                root <= {root[N-2:0], 1'b0};
            end else begin
                rem  <= sub[N-1:0];
                root <= {root[N-2:0], 1'b1};
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run; a $fatal in the testbench gives a failing exit status
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tb_esprit_eigen -f src.f \
    && ./obj_dir/Vtb_esprit_eigen \
    || { echo "simulation failed"; exit 1; }

// ==== src.f ====
hw/eig_pkg.sv
hw/lane_if.sv
hw/sample_fifo.sv
hw/eig_dispatch.sv
hw/sqrt_lane.sv
hw/eig_collect.sv
hw/esprit_eigen_top.sv
bench/tb_esprit_eigen.sv
